/* Makefile */
# Verilator lint, simulation and cleanup for the credit loop testbench.

VERILATOR  := verilator
TOP        := tb_credit_loop
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "=== PASS ===" $(LOG); then \
	  echo "Simulation passed."; \
	else \
	  echo "Simulation failed, see $(LOG)."; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/credit_counter.sv */
// Up/down credit counter with reload on reset, withholding and a combinational available count.

`timescale 1ns/1ps

module credit_counter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         incr_valid,
  input  logic                         decr_valid,
  input  logic [credit_pkg::CNT_W-1:0] withhold,
  output logic                         decr_ready,
  output logic [credit_pkg::CNT_W-1:0] value,
  output logic [credit_pkg::CNT_W-1:0] available
);

  // Stored count before this cycle's increment, decrement and withhold.
  logic [credit_pkg::CNT_W-1:0] count_q;

  // One extra bit so the same-cycle increment cannot wrap.
  logic [credit_pkg::CNT_W:0] count_plus_incr;
  logic [credit_pkg::CNT_W:0] avail_wide;
  logic [credit_pkg::CNT_W:0] count_next;

  // A credit leaves the counter on this cycle.
  logic decr;

  // --------------------------------------------------
  // Available credit
  // --------------------------------------------------

  // An incoming credit can be passed straight out in the same cycle.
  assign count_plus_incr = {1'b0, count_q} + {{credit_pkg::CNT_W{1'b0}}, incr_valid};

  // Withheld credits stay in the count but cannot be spent.
  // The result floors at zero when more is withheld than is held.
  always_comb begin
    if (count_plus_incr > {1'b0, withhold}) begin
      avail_wide = count_plus_incr - {1'b0, withhold};
    end else begin
      avail_wide = '0;
    end
  end

  // The floored difference never exceeds MAX_CREDIT, so the top bit is always zero.
  assign available  = avail_wide[credit_pkg::CNT_W-1:0];
  assign decr_ready = (available != '0);
  assign decr       = decr_valid && decr_ready;
  assign value      = count_q;

  // --------------------------------------------------
  // Count register
  // --------------------------------------------------

  // A decrement is only granted when available is nonzero, so this cannot go negative.
  assign count_next = count_plus_incr - {{credit_pkg::CNT_W{1'b0}}, decr};

  // Reset reloads the full credit pool.
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= credit_pkg::CREDIT_FULL;
    end else begin
      count_q <= count_next[credit_pkg::CNT_W-1:0];
    end
  end

  // Pop credits and push credits together must never create credit out of nothing.
  count_le_max_a : assert property (
    @(posedge clk) disable iff (rst)
    count_q <= credit_pkg::CREDIT_FULL
  );

endmodule

/* rtl/credit_link.sv */
// Fixed-delay link carrying flits and sender reset forward, credit returns backward.

`timescale 1ns/1ps

module credit_link (
  input  logic                    clk,
  input  logic                    rst,
  input  credit_pkg::flit_t       fwd_in,
  input  logic                    fwd_rst_in,
  input  credit_pkg::credit_ret_t bwd_in,
  output credit_pkg::flit_t       fwd_out,
  output logic                    fwd_rst_out,
  output credit_pkg::credit_ret_t bwd_out
);

  // Stage 0 takes the input and the last stage drives the output.
  logic [credit_pkg::LINK_DELAY-1:0] fwd_valid_q;
  logic [credit_pkg::LINK_DELAY-1:0] fwd_rst_q;
  logic [credit_pkg::LINK_DELAY-1:0] bwd_credit_q;
  logic [credit_pkg::LINK_DELAY-1:0] bwd_rst_q;
  logic [credit_pkg::LINK_DELAY-1:0][credit_pkg::DATA_W-1:0] fwd_data_q;

  // Reset empties both directions and marks both ends as being in reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_valid_q  <= '0;
      bwd_credit_q <= '0;
      fwd_rst_q    <= '1;
      bwd_rst_q    <= '1;
    end else begin
      fwd_valid_q[0]  <= fwd_in.valid;
      fwd_rst_q[0]    <= fwd_rst_in;
      bwd_credit_q[0] <= bwd_in.credit;
      bwd_rst_q[0]    <= bwd_in.receiver_in_reset;
      for (int i = 1; i < credit_pkg::LINK_DELAY; i++) begin
        fwd_valid_q[i]  <= fwd_valid_q[i-1];
        fwd_rst_q[i]    <= fwd_rst_q[i-1];
        bwd_credit_q[i] <= bwd_credit_q[i-1];
        bwd_rst_q[i]    <= bwd_rst_q[i-1];
      end
    end
  end

  // The data only means something alongside its valid bit.
  always_ff @(posedge clk) begin
    fwd_data_q[0] <= fwd_in.data;
    for (int i = 1; i < credit_pkg::LINK_DELAY; i++) begin
      fwd_data_q[i] <= fwd_data_q[i-1];
    end
  end

  always_comb begin
    fwd_out.valid             = fwd_valid_q[credit_pkg::LINK_DELAY-1];
    fwd_out.data              = fwd_data_q[credit_pkg::LINK_DELAY-1];
    fwd_rst_out               = fwd_rst_q[credit_pkg::LINK_DELAY-1];
    bwd_out.credit            = bwd_credit_q[credit_pkg::LINK_DELAY-1];
    bwd_out.receiver_in_reset = bwd_rst_q[credit_pkg::LINK_DELAY-1];
  end

endmodule

/* rtl/credit_loop_top.sv */
// Top level of the credit loop joining sender, link, receiver and receiver buffer.

`timescale 1ns/1ps

module credit_loop_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          sender_rst,
  input  logic                          in_valid,
  input  logic [credit_pkg::DATA_W-1:0] in_data,
  output logic                          in_ready,
  output logic                          out_valid,
  output logic [credit_pkg::DATA_W-1:0] out_data,
  input  logic                          out_ready,
  input  logic [credit_pkg::CNT_W-1:0]  credit_withhold,
  output logic [credit_pkg::CNT_W-1:0]  credit_count,
  output logic [credit_pkg::CNT_W-1:0]  credit_available
);

  // --------------------------------------------------
  // Link signals
  // --------------------------------------------------

  // Sender end of the link.
  credit_pkg::flit_t       snd_flit;
  logic                    snd_in_reset;
  credit_pkg::credit_ret_t snd_credit_ret;

  // Receiver end of the link.
  credit_pkg::flit_t       rcv_push;
  logic                    rcv_sender_in_reset;
  credit_pkg::credit_ret_t rcv_credit_ret;

  // Between receiver and buffer, which share one reset and no delay.
  credit_pkg::flit_t       buf_wr;
  logic                    buf_pop_credit;

  credit_sender credit_sender (
    .clk,
    .rst,
    .sender_rst,
    .in_valid,
    .in_data,
    .credit_ret     (snd_credit_ret),
    .in_ready,
    .flit           (snd_flit),
    .sender_in_reset(snd_in_reset)
  );

  // The link sits on the receiver's reset; sender resets travel through it as a bit.
  credit_link credit_link (
    .clk,
    .rst,
    .fwd_in     (snd_flit),
    .fwd_rst_in (snd_in_reset),
    .bwd_in     (rcv_credit_ret),
    .fwd_out    (rcv_push),
    .fwd_rst_out(rcv_sender_in_reset),
    .bwd_out    (snd_credit_ret)
  );

  credit_receiver credit_receiver (
    .clk,
    .rst,
    .push                (rcv_push),
    .push_sender_in_reset(rcv_sender_in_reset),
    .pop_credit          (buf_pop_credit),
    .credit_withhold,
    .credit_ret          (rcv_credit_ret),
    .pop                 (buf_wr),
    .credit_count,
    .credit_available
  );

  rx_fifo rx_fifo (
    .clk,
    .rst,
    .wr        (buf_wr),
    .out_ready,
    .out_valid,
    .out_data,
    .pop_credit(buf_pop_credit)
  );

endmodule

/* rtl/credit_pkg.sv */
// Shared sizes, link structs and sender state encoding for the credit loop.

package credit_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------

  // Width of one data word.
  localparam int DATA_W = 16;

  // Receiver buffer depth, which is also the total number of credits in circulation.
  localparam int MAX_CREDIT = 8;

  // Any credit count must be able to hold MAX_CREDIT itself.
  localparam int CNT_W = $clog2(MAX_CREDIT + 1);

  // Index width for the receiver buffer.
  localparam int PTR_W = $clog2(MAX_CREDIT);

  // Cycles of delay through the link, the same in each direction.
  localparam int LINK_DELAY = 2;

  // Full credit count, sized to CNT_W for compares and reset loads.
  localparam logic [CNT_W-1:0] CREDIT_FULL = CNT_W'(MAX_CREDIT);

  // Last buffer index, where the pointers wrap back to zero.
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(MAX_CREDIT - 1);

  // --------------------------------------------------
  // Link payloads
  // --------------------------------------------------

  // Forward word from sender to receiver.
  // A set valid bit means the sender has spent one credit on it.
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } flit_t;

  // Backward return from receiver to sender.
  // One credit at most per cycle, plus the receiver reset indication.
  typedef struct packed {
    logic credit;
    logic receiver_in_reset;
  } credit_ret_t;

  // Sender FSM.
  // SND_RESET waits until both sides are out of reset.
  typedef enum logic [0:0] {
    SND_RESET,
    SND_RUN
  } sender_state_e;

endpackage

/* rtl/credit_receiver.sv */
// Receiver side of the credit loop, cutting pushes through to the buffer and issuing credits.

`timescale 1ns/1ps

module credit_receiver (
  input  logic                         clk,
  input  logic                         rst,
  input  credit_pkg::flit_t            push,
  input  logic                         push_sender_in_reset,
  input  logic                         pop_credit,
  input  logic [credit_pkg::CNT_W-1:0] credit_withhold,
  output credit_pkg::credit_ret_t      credit_ret,
  output credit_pkg::flit_t            pop,
  output logic [credit_pkg::CNT_W-1:0] credit_count,
  output logic [credit_pkg::CNT_W-1:0] credit_available
);

  // Either side in reset means the credit pool has to be rebuilt.
  logic either_rst;

  logic credit_incr_valid;
  logic credit_decr_valid;
  logic credit_decr_ready;

  // Words held in the buffer as seen from this side of the loop.
  logic [credit_pkg::CNT_W-1:0] occupancy_q;
  logic [credit_pkg::CNT_W:0]   occupancy_next;

  assign either_rst = rst || push_sender_in_reset;

  // --------------------------------------------------
  // Credit pool
  // --------------------------------------------------

  // Pop credits are dropped while either side is in reset.
  assign credit_incr_valid = pop_credit && !either_rst;

  // There is no stall on the link, so a credit goes out whenever one is available.
  assign credit_decr_valid = !either_rst;

  credit_counter credit_counter (
    .clk,
    .rst       (either_rst),
    .incr_valid(credit_incr_valid),
    .decr_valid(credit_decr_valid),
    .withhold  (credit_withhold),
    .decr_ready(credit_decr_ready),
    .value     (credit_count),
    .available (credit_available)
  );

  // The in-reset bit reflects only this side's own reset.
  always_comb begin
    credit_ret.credit            = credit_decr_valid && credit_decr_ready;
    credit_ret.receiver_in_reset = rst;
  end

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------

  // Zero-cycle cut-through into the buffer.
  // Words that arrive during reset are dropped.
  always_comb begin
    pop.valid = push.valid && !either_rst;
    pop.data  = push.data;
  end

  // --------------------------------------------------
  // Occupancy check
  // --------------------------------------------------

  assign occupancy_next = {1'b0, occupancy_q} + {{credit_pkg::CNT_W{1'b0}}, pop.valid}
                        - {{credit_pkg::CNT_W{1'b0}}, credit_incr_valid};

  always_ff @(posedge clk) begin
    if (either_rst) begin
      occupancy_q <= '0;
    end else begin
      occupancy_q <= occupancy_next[credit_pkg::CNT_W-1:0];
    end
  end

  // The sender must never push more words than the buffer has room for.
  no_push_overflow_a : assert property (
    @(posedge clk) disable iff (either_rst)
    push.valid |-> (occupancy_next <= {1'b0, credit_pkg::CREDIT_FULL})
  );

  // The link still reports the sender in reset on the cycle after rst.
  // So nothing reaches the buffer there either.
  pop_valid_low_in_rst_a : assert property (
    @(posedge clk)
    rst |=> !pop.valid
  );

endmodule

/* rtl/credit_sender.sv */
// Sender side of the credit loop, spending one held credit per accepted upstream word.

`timescale 1ns/1ps

module credit_sender (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          sender_rst,
  input  logic                          in_valid,
  input  logic [credit_pkg::DATA_W-1:0] in_data,
  input  credit_pkg::credit_ret_t       credit_ret,
  output logic                          in_ready,
  output credit_pkg::flit_t             flit,
  output logic                          sender_in_reset
);

  credit_pkg::sender_state_e state_q;
  credit_pkg::sender_state_e state_d;

  // Credits currently held by the sender.
  logic [credit_pkg::CNT_W-1:0] count_q;
  logic [credit_pkg::CNT_W-1:0] count_d;
  logic [credit_pkg::CNT_W:0]   count_sum;

  // An upstream word transfers on this cycle.
  logic accept;

  // The sender side is reset by the shared reset or by its own.
  assign sender_in_reset = rst || sender_rst;

  // --------------------------------------------------
  // Upstream handshake
  // --------------------------------------------------

  // in_ready depends only on state, never on in_valid.
  assign in_ready = (state_q == credit_pkg::SND_RUN) && (count_q != '0);
  assign accept   = in_valid && in_ready;

  // Each accepted word goes onto the link in the same cycle.
  always_comb begin
    flit.valid = accept;
    flit.data  = in_data;
  end

  // --------------------------------------------------
  // FSM and credit count
  // --------------------------------------------------

  // Wait in SND_RESET until the receiver reports it is out of reset.
  // A receiver reset seen while running sends the sender back to wait.
  always_comb begin
    state_d = state_q;
    case (state_q)
      credit_pkg::SND_RESET: begin
        if (!credit_ret.receiver_in_reset) begin
          state_d = credit_pkg::SND_RUN;
        end
      end
      credit_pkg::SND_RUN: begin
        if (credit_ret.receiver_in_reset) begin
          state_d = credit_pkg::SND_RESET;
        end
      end
      default: state_d = credit_pkg::SND_RESET;
    endcase
  end

  // Returned credits add and accepted words subtract.
  assign count_sum = {1'b0, count_q} + {{credit_pkg::CNT_W{1'b0}}, credit_ret.credit}
                   - {{credit_pkg::CNT_W{1'b0}}, accept};

  // Credits only count while running. The receiver rebuilds its pool on reset.
  always_comb begin
    if ((state_q == credit_pkg::SND_RUN) && (state_d == credit_pkg::SND_RUN)) begin
      count_d = count_sum[credit_pkg::CNT_W-1:0];
    end else begin
      count_d = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (sender_in_reset) begin
      state_q <= credit_pkg::SND_RESET;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
    end
  end

  // The receiver never hands out more credit than the buffer holds.
  sender_count_le_max_a : assert property (
    @(posedge clk) disable iff (sender_in_reset)
    count_q <= credit_pkg::CREDIT_FULL
  );

endmodule

/* rtl/rx_fifo.sv */
// Receiver buffer of MAX_CREDIT words that returns one pop credit per word taken downstream.

`timescale 1ns/1ps

module rx_fifo (
  input  logic                          clk,
  input  logic                          rst,
  input  credit_pkg::flit_t             wr,
  input  logic                          out_ready,
  output logic                          out_valid,
  output logic [credit_pkg::DATA_W-1:0] out_data,
  output logic                          pop_credit
);

  // Storage for the words in flight between receiver and consumer.
  logic [credit_pkg::DATA_W-1:0] mem [credit_pkg::MAX_CREDIT];

  logic [credit_pkg::PTR_W-1:0] wr_ptr_q;
  logic [credit_pkg::PTR_W-1:0] rd_ptr_q;
  logic [credit_pkg::CNT_W-1:0] count_q;

  logic full;
  logic pop;

  // --------------------------------------------------
  // Downstream handshake
  // --------------------------------------------------

  // Valid comes straight from the count register, one cycle after a write.
  assign out_valid = (count_q != '0);
  assign out_data  = mem[rd_ptr_q];
  assign full      = (count_q == credit_pkg::CREDIT_FULL);
  assign pop       = out_valid && out_ready;

  // Each word taken frees one buffer entry, which goes back as a credit.
  assign pop_credit = pop;

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  // Writes land on the edge that ends the cycle the flit arrives.
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr_ptr_q] <= wr.data;
    end
  end

  // Pointers wrap at the last entry and the count tracks the fill level.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr.valid) begin
        wr_ptr_q <= (wr_ptr_q == credit_pkg::PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == credit_pkg::PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr.valid, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // The credit loop as a whole must keep writes away from a full buffer.
  no_write_when_full_a : assert property (
    @(posedge clk) disable iff (rst)
    wr.valid |-> !full
  );

endmodule

/* sim/tb_credit_loop.sv */
// Testbench for the credit loop, driving random traffic and checking it against a queue model.

`timescale 1ns/1ps

module tb_credit_loop;

  localparam int RESET_CYCLES = 10;
  // A credit takes LINK_DELAY cycles each way, plus a little margin for the FSM and buffer.
  localparam int SETTLE_CYCLES = 2 * credit_pkg::LINK_DELAY + 4;
  localparam int WAIT_LIMIT = 2000;

  logic                          clk;
  logic                          rst;
  logic                          sender_rst;
  logic                          in_valid;
  logic [credit_pkg::DATA_W-1:0] in_data;
  logic                          in_ready;
  logic                          out_valid;
  logic [credit_pkg::DATA_W-1:0] out_data;
  logic                          out_ready;
  logic [credit_pkg::CNT_W-1:0]  credit_withhold;
  logic [credit_pkg::CNT_W-1:0]  credit_count;
  logic [credit_pkg::CNT_W-1:0]  credit_available;

  // Words accepted upstream and not yet delivered, oldest at the front.
  logic [credit_pkg::DATA_W-1:0] model_q[$];

  // Withhold value that the next falling edge applies.
  logic [credit_pkg::CNT_W-1:0] withhold_set;

  int checks;
  int errors;
  int accepted;
  int delivered;
  int w;
  int got;

  credit_loop_top dut0 (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // --------------------------------------------------
  // Run control
  // --------------------------------------------------

  task automatic end_run();
    $display("Checks: %0d, errors: %0d, words in: %0d, words out: %0d",
             checks, errors, accepted, delivered);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout at t=%0t while waiting for %s.", $time, what);
    end_run();
  endtask

  // --------------------------------------------------
  // Cycle driver and model
  // --------------------------------------------------

  // Drives one cycle on the falling edge, then logs the handshakes that the next edge commits.
  task automatic step(input logic valid, input logic ready);
    int unsigned                   rnd;
    logic [credit_pkg::DATA_W-1:0] exp;
    @(negedge clk);
    rnd             = $urandom;
    in_valid        = valid;
    in_data         = rnd[credit_pkg::DATA_W-1:0];
    out_ready       = ready;
    credit_withhold = withhold_set;
    #1;
    if (in_valid && in_ready) begin
      model_q.push_back(in_data);
      accepted++;
    end
    if (out_valid && out_ready) begin
      delivered++;
      checks++;
      if (model_q.size() == 0) begin
        errors++;
        $display("FAIL t=%0t: word %h delivered with nothing outstanding", $time, out_data);
      end else begin
        exp = model_q.pop_front();
        if (out_data != exp) begin
          errors++;
          $display("FAIL t=%0t: out_data is %h, expected %h", $time, out_data, exp);
        end
      end
    end
  endtask

  // Holds rst (or only sender_rst) with no traffic, then checks the rebuilt credit pool.
  task automatic hold_reset(input logic full_rst);
    int exp_avail;
    @(negedge clk);
    rst             = full_rst;
    sender_rst      = 1'b1;
    in_valid        = 1'b0;
    credit_withhold = withhold_set;
    repeat (RESET_CYCLES) @(negedge clk);
    // The receiver pool is full and only the withheld part is unavailable.
    exp_avail = credit_pkg::MAX_CREDIT - int'(withhold_set);
    checks++;
    if (in_ready || out_valid) begin
      errors++;
      $display("FAIL t=%0t: in_ready or out_valid high during reset", $time);
    end
    checks++;
    if (int'(credit_count) != credit_pkg::MAX_CREDIT) begin
      errors++;
      $display("FAIL t=%0t: credit_count %0d in reset, expected %0d",
               $time, credit_count, credit_pkg::MAX_CREDIT);
    end
    checks++;
    if (int'(credit_available) != exp_avail) begin
      errors++;
      $display("FAIL t=%0t: credit_available %0d in reset, expected %0d",
               $time, credit_available, exp_avail);
    end
    rst        = 1'b0;
    sender_rst = 1'b0;
  endtask

  // Waits until the receiver has nothing left to issue, then lets the last returns land.
  task automatic wait_settled();
    int n;
    n = 0;
    while ((credit_available != '0 || out_valid) && n < WAIT_LIMIT) begin
      step(1'b0, 1'b1);
      n++;
    end
    if (n >= WAIT_LIMIT) report_timeout("the credits to settle");
    repeat (SETTLE_CYCLES) step(1'b0, 1'b1);
  endtask

  // Offers words with the consumer stalled and counts how many the sender takes.
  task automatic fill_until_stall(output int taken);
    int quiet;
    int n;
    int start;
    start = accepted;
    quiet = 0;
    n     = 0;
    while (quiet < SETTLE_CYCLES && n < WAIT_LIMIT) begin
      step(1'b1, 1'b0);
      quiet = in_ready ? 0 : quiet + 1;
      n++;
    end
    if (n >= WAIT_LIMIT) report_timeout("the sender to stall");
    taken = accepted - start;
    // Nothing drains, so no credit may come back to reopen the upstream side.
    repeat (SETTLE_CYCLES) begin
      step(1'b1, 1'b0);
      checks++;
      if (in_ready) begin
        errors++;
        $display("FAIL t=%0t: in_ready rose while the consumer was stalled", $time);
      end
    end
  endtask

  // Lets the consumer take everything that is outstanding.
  task automatic drain(output int taken);
    int n;
    int start;
    start = delivered;
    n     = 0;
    while ((model_q.size() != 0 || out_valid) && n < WAIT_LIMIT) begin
      step(1'b0, 1'b1);
      n++;
    end
    if (n >= WAIT_LIMIT) report_timeout("the buffer to drain");
    taken = delivered - start;
  endtask

  // Random valid and ready until the given number of words has come out.
  task automatic run_traffic(input int words);
    int n;
    int target;
    target = delivered + words;
    n      = 0;
    while (delivered < target && n < 10 * WAIT_LIMIT) begin
      step(($urandom % 4) != 0, ($urandom % 3) != 0);
      n++;
    end
    if (n >= 10 * WAIT_LIMIT) report_timeout("random traffic to complete");
  endtask

  // --------------------------------------------------
  // Credit accounting
  // --------------------------------------------------

  // On an idle loop the receiver count and the sender credits add up to the whole pool.
  // The receiver keeps the withheld credits, so the sender can hold no more than the rest.
  task automatic check_credit_sum(input int withheld);
    int held;
    int rcv;
    int out_n;
    wait_settled();
    rcv = int'(credit_count);
    fill_until_stall(held);
    checks++;
    if (rcv + held != credit_pkg::MAX_CREDIT) begin
      errors++;
      $display("FAIL t=%0t: receiver %0d plus sender %0d credits, expected %0d",
               $time, rcv, held, credit_pkg::MAX_CREDIT);
    end
    checks++;
    if (held > credit_pkg::MAX_CREDIT - withheld) begin
      errors++;
      $display("FAIL t=%0t: %0d words accepted with %0d withheld",
               $time, held, withheld);
    end
    drain(out_n);
    checks++;
    if (out_n != credit_pkg::MAX_CREDIT - withheld) begin
      errors++;
      $display("FAIL t=%0t: %0d words drained, expected %0d",
               $time, out_n, credit_pkg::MAX_CREDIT - withheld);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(32'ha66e2f57));
    rst             = 1'b1;
    sender_rst      = 1'b1;
    in_valid        = 1'b0;
    in_data         = '0;
    out_ready       = 1'b0;
    credit_withhold = '0;
    withhold_set    = '0;
    checks          = 0;
    errors          = 0;
    accepted        = 0;
    delivered       = 0;

    hold_reset(1'b1);
    check_credit_sum(0);

    // Ordered delivery under random back-pressure on both sides.
    run_traffic(2000);
    drain(got);

    // Withholding takes effect when the pool is rebuilt by a reset.
    w            = 1 + int'($urandom % (credit_pkg::MAX_CREDIT - 1));
    withhold_set = w[credit_pkg::CNT_W-1:0];
    hold_reset(1'b1);
    check_credit_sum(w);
    withhold_set = '0;
    check_credit_sum(0);

    // Sender-only reset, then traffic has to pick up again without loss.
    hold_reset(1'b0);
    check_credit_sum(0);
    run_traffic(500);
    drain(got);

    end_run();
  end

endmodule

/* tb.f */
rtl/credit_pkg.sv
rtl/credit_counter.sv
rtl/credit_receiver.sv
rtl/credit_sender.sv
rtl/rx_fifo.sv
rtl/credit_link.sv
rtl/credit_loop_top.sv
sim/tb_credit_loop.sv
